//--- logic/bpuPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the branch prediction unit with PC width, branch
// type codes, 2-bit counter encodings and the call return offset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package bpuPkg;

    // one word
    localparam int addrWidth = 32;

    // branch kind as stored in the history table
    typedef enum logic [1:0] {
        brNone = 2'b00,
        brCall = 2'b01,
        brRetn = 2'b10,
        brImme = 2'b11
    } branchType_t;

    // saturating counter states with the top bit as the taken prediction
    localparam logic [1:0] ctrStrongNt = 2'b00;
    localparam logic [1:0] ctrWeakNt   = 2'b01;
    localparam logic [1:0] ctrWeakT    = 2'b10;
    localparam logic [1:0] ctrStrongT  = 2'b11;

    // call plus its delay slot
    localparam logic [addrWidth-1:0] returnOffset = 32'd8;

endpackage

`default_nettype wire

//--- logic/branchHistoryTable.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped tagged table of branch targets, types and 2-bit
// counters with an async lookup and a resolution write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module branchHistoryTable import bpuPkg::*; #(
    parameter int indexWidth = 6
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [addrWidth-1:0]                    lookupPc,
    input  logic                                    resolveValid,
    input  logic [addrWidth-1:0]                    resolvePc,
    input  logic [addrWidth-1:0]                    resolveTarget,
    input  branchType_t                             resolveType,
    input  logic                                    resolveTaken,
    input  logic                                    resolveHit,
    input  logic [1:0]                              resolveCount,
    output logic                                    entryValid,
    output logic [addrWidth-indexWidth-3:0]         entryTag,
    output logic [addrWidth-1:0]                    entryTarget,
    output branchType_t                             entryType,
    output logic [1:0]                              entryCount
);

    localparam int numEntries = 2 ** indexWidth;
    localparam int tagWidth   = addrWidth - indexWidth - 2;

    logic [numEntries-1:0]   validBits;
    logic [tagWidth-1:0]     tagMem [numEntries];
    logic [addrWidth-1:0]    targetMem [numEntries];
    branchType_t             typeMem [numEntries];
    logic [1:0]              countMem [numEntries];

    logic [indexWidth-1:0]   lookupIndex;
    logic [indexWidth-1:0]   writeIndex;
    logic [tagWidth-1:0]     writeTag;
    logic [1:0]              writeCount;

    // index skips the byte offset and the tag is everything above it
    assign lookupIndex = lookupPc[indexWidth+1:2];
    assign writeIndex  = resolvePc[indexWidth+1:2];
    assign writeTag    = resolvePc[addrWidth-1:indexWidth+2];

    // fresh entries start weak and hits step toward the outcome and saturate
    always_comb begin
        if (!resolveHit) begin
            writeCount = resolveTaken ? ctrWeakT : ctrWeakNt;
        end else if (resolveTaken) begin
            writeCount = (resolveCount == ctrStrongT) ? resolveCount : resolveCount + 2'd1;
        end else begin
            writeCount = (resolveCount == ctrStrongNt) ? resolveCount : resolveCount - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (resolveValid) begin
            validBits[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resolveValid) begin
            tagMem[writeIndex]    <= writeTag;
            targetMem[writeIndex] <= resolveTarget;
            typeMem[writeIndex]   <= resolveType;
            countMem[writeIndex]  <= writeCount;
        end
    end

    // lookup sees the old contents during a write cycle
    assign entryValid  = validBits[lookupIndex];
    assign entryTag    = tagMem[lookupIndex];
    assign entryTarget = targetMem[lookupIndex];
    assign entryType   = typeMem[lookupIndex];
    assign entryCount  = countMem[lookupIndex];

endmodule

`default_nettype wire

//--- logic/returnAddressStack.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular call/return stack with a same-cycle push bypass
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module returnAddressStack import bpuPkg::*; #(
    parameter int rasDepth = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    resolveValid,
    input  logic [addrWidth-1:0]    resolvePc,
    input  branchType_t             resolveType,
    input  logic                    resolveRetnOk,
    output logic                    topValid,
    output logic [addrWidth-1:0]    topAddr
);

    localparam int ptrWidth = $clog2(rasDepth);

    logic [rasDepth-1:0]    slotValid;
    logic [addrWidth-1:0]   slotAddr [rasDepth];
    logic [ptrWidth-1:0]    topPtr;
    logic [ptrWidth-1:0]    belowPtr;
    logic                   pushEn;
    logic                   popEn;
    logic [addrWidth-1:0]   pushAddr;

    // pointer wraps since depth is a power of two
    assign belowPtr = topPtr - 1'b1;
    assign pushEn   = resolveValid && (resolveType == brCall);
    assign popEn    = resolveValid && (resolveType == brRetn) && resolveRetnOk;
    assign pushAddr = resolvePc + returnOffset;

    always_ff @(posedge clk) begin
        if (reset) begin
            topPtr    <= '0;
            slotValid <= '0;
            for (int i = 0; i < rasDepth; i++) begin
                slotAddr[i] <= '0;
            end
        end else if (pushEn) begin
            slotValid[topPtr] <= 1'b1;
            slotAddr[topPtr]  <= pushAddr;
            topPtr            <= topPtr + 1'b1;
        end else if (popEn) begin
            // popped slot no longer holds a live return
            slotValid[belowPtr] <= 1'b0;
            topPtr              <= belowPtr;
        end
    end

    // a call resolving now is visible to the lookup in the same cycle
    assign topValid = pushEn ? 1'b1 : slotValid[belowPtr];
    assign topAddr  = pushEn ? pushAddr : slotAddr[belowPtr];

endmodule

`default_nettype wire

//--- logic/predictionStage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch-side lookup register, tag compare and predicted target selection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module predictionStage import bpuPkg::*; #(
    parameter int indexWidth = 6
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ifWr,
    input  logic                                ifFlush,
    input  logic [addrWidth-1:0]                preIfPc,
    input  logic                                entryValid,
    input  logic [addrWidth-indexWidth-3:0]     entryTag,
    input  logic [addrWidth-1:0]                entryTarget,
    input  branchType_t                         entryType,
    input  logic [1:0]                          entryCount,
    input  logic                                topValid,
    input  logic [addrWidth-1:0]                topAddr,
    output logic [addrWidth-1:0]                target,
    output logic                                predTaken,
    output branchType_t                         predType,
    output logic                                predHit,
    output logic [1:0]                          predCount,
    output logic                                predValid
);

    localparam int tagWidth = addrWidth - indexWidth - 2;

    logic                   regEntryValid;
    logic [tagWidth-1:0]    regEntryTag;
    logic [addrWidth-1:0]   regEntryTarget;
    branchType_t            regEntryType;
    logic [1:0]             regEntryCount;
    logic                   regTopValid;
    logic [addrWidth-1:0]   regTopAddr;
    logic [tagWidth-1:0]    regPcTag;
    logic [addrWidth-1:0]   regPcAdd8;
    logic                   regSlotValid;

    always_ff @(posedge clk) begin
        if (reset || ifFlush) begin
            regEntryValid  <= 1'b0;
            regEntryTag    <= '0;
            regEntryTarget <= '0;
            regEntryType   <= brNone;
            regEntryCount  <= ctrStrongNt;
            regTopValid    <= 1'b0;
            regTopAddr     <= '0;
            regPcTag       <= '0;
            // cleared PC of zero gives a fall-through of 8
            regPcAdd8      <= returnOffset;
            regSlotValid   <= 1'b0;
        end else if (ifWr) begin
            regEntryValid  <= entryValid;
            regEntryTag    <= entryTag;
            regEntryTarget <= entryTarget;
            regEntryType   <= entryType;
            regEntryCount  <= entryCount;
            regTopValid    <= topValid;
            regTopAddr     <= topAddr;
            regPcTag       <= preIfPc[addrWidth-1:indexWidth+2];
            regPcAdd8      <= preIfPc + returnOffset;
            // the fetch after a taken prediction is the wrong path
            regSlotValid   <= ~predTaken;
        end
    end

    assign predHit = regEntryValid && (regEntryTag == regPcTag);

    always_comb begin
        target    = regPcAdd8;
        predTaken = 1'b0;
        if (predHit) begin
            case (regEntryType)
                brCall: begin
                    target    = regEntryTarget;
                    predTaken = 1'b1;
                end
                brRetn: begin
                    // empty stack falls back to the delay slot successor
                    target    = regTopValid ? regTopAddr : regPcAdd8;
                    predTaken = 1'b1;
                end
                brImme: begin
                    if (regEntryCount[1]) begin
                        target    = regEntryTarget;
                        predTaken = 1'b1;
                    end
                end
                default: begin
                    target    = regPcAdd8;
                    predTaken = 1'b0;
                end
            endcase
        end
    end

    assign predType  = predHit ? regEntryType : brNone;
    assign predCount = regEntryCount;
    assign predValid = regSlotValid;

endmodule

`default_nettype wire

//--- logic/branchPredictor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level joining the history table, the return address stack and
// the prediction register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module branchPredictor import bpuPkg::*; #(
    parameter int indexWidth = 6,
    parameter int rasDepth   = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [addrWidth-1:0]    preIfPc,
    input  logic                    ifWr,
    input  logic                    ifFlush,
    input  logic                    resolveValid,
    input  logic [addrWidth-1:0]    resolvePc,
    input  logic [addrWidth-1:0]    resolveTarget,
    input  branchType_t             resolveType,
    input  logic                    resolveTaken,
    input  logic                    resolveHit,
    input  logic [1:0]              resolveCount,
    input  logic                    resolveRetnOk,
    output logic [addrWidth-1:0]    target,
    output logic                    predTaken,
    output branchType_t             predType,
    output logic                    predHit,
    output logic [1:0]              predCount,
    output logic                    predValid
);

    localparam int tagWidth = addrWidth - indexWidth - 2;

    logic                   entryValid;
    logic [tagWidth-1:0]    entryTag;
    logic [addrWidth-1:0]   entryTarget;
    branchType_t            entryType;
    logic [1:0]             entryCount;
    logic                   topValid;
    logic [addrWidth-1:0]   topAddr;

    branchHistoryTable #(
        .indexWidth(indexWidth)
    ) bht (
        .clk(clk),
        .reset(reset),
        .lookupPc(preIfPc),
        .resolveValid(resolveValid),
        .resolvePc(resolvePc),
        .resolveTarget(resolveTarget),
        .resolveType(resolveType),
        .resolveTaken(resolveTaken),
        .resolveHit(resolveHit),
        .resolveCount(resolveCount),
        .entryValid(entryValid),
        .entryTag(entryTag),
        .entryTarget(entryTarget),
        .entryType(entryType),
        .entryCount(entryCount)
    );

    returnAddressStack #(
        .rasDepth(rasDepth)
    ) ras (
        .clk(clk),
        .reset(reset),
        .resolveValid(resolveValid),
        .resolvePc(resolvePc),
        .resolveType(resolveType),
        .resolveRetnOk(resolveRetnOk),
        .topValid(topValid),
        .topAddr(topAddr)
    );

    predictionStage #(
        .indexWidth(indexWidth)
    ) predStage (
        .clk(clk),
        .reset(reset),
        .ifWr(ifWr),
        .ifFlush(ifFlush),
        .preIfPc(preIfPc),
        .entryValid(entryValid),
        .entryTag(entryTag),
        .entryTarget(entryTarget),
        .entryType(entryType),
        .entryCount(entryCount),
        .topValid(topValid),
        .topAddr(topAddr),
        .target(target),
        .predTaken(predTaken),
        .predType(predType),
        .predHit(predHit),
        .predCount(predCount),
        .predValid(predValid)
    );

endmodule

`default_nettype wire

//--- tests/bpuModel.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench reference model with the counter update rule, the expected
// taken flag and the expected predicted target
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BPU_MODEL_SVH
`define BPU_MODEL_SVH

// fresh entries start weak and hits move one level within 00 to 11
function automatic logic [1:0] nextCount(input logic hit, input logic taken,
                                         input logic [1:0] oldCount);
    int level;
    level = oldCount;
    if (!hit) begin
        return taken ? ctrWeakT : ctrWeakNt;
    end
    level = taken ? level + 1 : level - 1;
    if (level > 3) begin
        level = 3;
    end else if (level < 0) begin
        level = 0;
    end
    return level[1:0];
endfunction

// calls and returns always go while conditionals follow the counter
function automatic logic takenFor(input logic hit, input branchType_t kind,
                                  input logic [1:0] count);
    if (!hit || kind == brNone) begin
        return 1'b0;
    end
    return (kind == brImme) ? count[1] : 1'b1;
endfunction

function automatic logic [addrWidth-1:0] targetFor(
    input logic [addrWidth-1:0] pc, input logic hit, input branchType_t kind,
    input logic [1:0] count, input logic [addrWidth-1:0] stored,
    input logic stackValid, input logic [addrWidth-1:0] stackTop);
    if (!takenFor(hit, kind, count)) begin
        return pc + returnOffset;
    end
    // an empty stack falls through past the delay slot
    if (kind == brRetn) begin
        return stackValid ? stackTop : pc + returnOffset;
    end
    return stored;
endfunction

`endif

//--- tests/branchPredictorTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the branch predictor with clock, reset, lookup
// and resolution drivers, six directed tests, timeout and final report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module branchPredictorTb import bpuPkg::*; ();

    localparam int tbIndexWidth  = 6;
    localparam int timeoutCycles = 400;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [addrWidth-1:0]   preIfPc;
    logic                   ifWr;
    logic                   ifFlush;
    logic                   resolveValid;
    logic [addrWidth-1:0]   resolvePc;
    logic [addrWidth-1:0]   resolveTarget;
    branchType_t            resolveType;
    logic                   resolveTaken;
    logic                   resolveHit;
    logic [1:0]             resolveCount;
    logic                   resolveRetnOk;
    logic [addrWidth-1:0]   target;
    logic                   predTaken;
    branchType_t            predType;
    logic                   predHit;
    logic [1:0]             predCount;
    logic                   predValid;

    integer                 seed;
    int                     errorCount = 0;
    int                     cycleCount = 0;
    logic [addrWidth-1:0]   rasModel [$];
    logic [addrWidth-1:0]   immPc;
    logic [addrWidth-1:0]   immTarget;
    logic [1:0]             immCount;
    logic [addrWidth-1:0]   callPcA;
    logic [addrWidth-1:0]   callTgtA;
    logic [addrWidth-1:0]   retPc;
    logic [1:0]             retCount;

    `include "bpuModel.svh"

    branchPredictor #(
        .indexWidth(tbIndexWidth),
        .rasDepth(8)
    ) u_dut (.*);

    always #2 clk = ~clk;

    // random tag bits around a chosen table index
    function automatic logic [addrWidth-1:0] makePc(input int index);
        logic [addrWidth-1:0] raw;
        raw = $random(seed);
        return {raw[addrWidth-1:tbIndexWidth+2], index[tbIndexWidth-1:0], 2'b00};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            errorCount++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic expectLookup(input logic [addrWidth-1:0] pc, input logic hit,
                                input branchType_t kind, input logic [1:0] count,
                                input logic [addrWidth-1:0] stored);
        logic                   stackValid;
        logic [addrWidth-1:0]   stackTop;
        stackValid = (rasModel.size() > 0);
        stackTop   = stackValid ? rasModel[$] : '0;
        checkValue("predHit", predHit, hit);
        checkValue("predType", predType, hit ? kind : brNone);
        checkValue("predTaken", predTaken, takenFor(hit, kind, count));
        checkValue("target", target,
                   targetFor(pc, hit, kind, count, stored, stackValid, stackTop));
        if (hit) begin
            checkValue("predCount", predCount, count);
        end
    endtask

    task automatic lookup(input logic [addrWidth-1:0] pc);
        @(posedge clk);
        #1;
        preIfPc = pc;
        ifWr    = 1'b1;
        @(posedge clk);
        #1;
        ifWr = 1'b0;
    endtask

    task automatic driveResolve(input logic [addrWidth-1:0] pc, input logic [addrWidth-1:0] dest,
                                input branchType_t kind, input logic taken, input logic hit,
                                input logic [1:0] count, input logic retnOk);
        resolveValid  = 1'b1;
        resolvePc     = pc;
        resolveTarget = dest;
        resolveType   = kind;
        resolveTaken  = taken;
        resolveHit    = hit;
        resolveCount  = count;
        resolveRetnOk = retnOk;
        // stack model where calls push the return point and good returns pop
        if (kind == brCall) begin
            rasModel.push_back(pc + returnOffset);
        end else if (kind == brRetn && retnOk && rasModel.size() > 0) begin
            void'(rasModel.pop_back());
        end
    endtask

    task automatic resolveBranch(input logic [addrWidth-1:0] pc, input logic [addrWidth-1:0] dest,
                                 input branchType_t kind, input logic taken, input logic hit,
                                 input logic [1:0] count, input logic retnOk);
        @(posedge clk);
        #1;
        driveResolve(pc, dest, kind, taken, hit, count, retnOk);
        @(posedge clk);
        #1;
        resolveValid = 1'b0;
    endtask

    task automatic coldMiss();
        logic [addrWidth-1:0] pc;
        pc = makePc(1);
        checkValue("predValid", predValid, 1'b0);
        lookup(pc);
        expectLookup(pc, 1'b0, brNone, ctrStrongNt, '0);
        checkValue("predValid", predValid, 1'b1);
    endtask

    task automatic counterTraining();
        logic [6:0] outcomes;
        logic [1:0] count;
        // up to saturation, down through the flip to the floor, one step back
        outcomes  = 7'b1000011;
        immPc     = makePc(2);
        immTarget = makePc(40);
        resolveBranch(immPc, immTarget, brImme, 1'b1, 1'b0, ctrStrongNt, 1'b0);
        count = nextCount(1'b0, 1'b1, ctrStrongNt);
        lookup(immPc);
        expectLookup(immPc, 1'b1, brImme, count, immTarget);
        checkValue("predCount", predCount, ctrWeakT);
        for (int i = 0; i < 7; i++) begin
            resolveBranch(immPc, immTarget, brImme, outcomes[i], 1'b1, count, 1'b0);
            count = nextCount(1'b1, outcomes[i], count);
            lookup(immPc);
            expectLookup(immPc, 1'b1, brImme, count, immTarget);
        end
        immCount = count;
    endtask

    task automatic callAndReturn();
        callPcA  = makePc(10);
        callTgtA = makePc(41);
        retPc    = makePc(20);
        resolveBranch(callPcA, callTgtA, brCall, 1'b1, 1'b0, ctrStrongNt, 1'b0);
        resolveBranch(makePc(11), makePc(42), brCall, 1'b1, 1'b0, ctrStrongNt, 1'b0);
        // install the return without popping
        resolveBranch(retPc, '0, brRetn, 1'b1, 1'b0, ctrStrongNt, 1'b0);
        retCount = nextCount(1'b0, 1'b1, ctrStrongNt);
        lookup(callPcA);
        expectLookup(callPcA, 1'b1, brCall, ctrWeakT, callTgtA);
        // two pops and then the empty stack falls back to PC+8
        for (int i = 0; i < 3; i++) begin
            lookup(retPc);
            expectLookup(retPc, 1'b1, brRetn, retCount, '0);
            resolveBranch(retPc, '0, brRetn, 1'b1, 1'b1, retCount, i < 2);
            retCount = nextCount(1'b1, 1'b1, retCount);
        end
    endtask

    task automatic pushBypass();
        logic [addrWidth-1:0] callPcC;
        callPcC = makePc(12);
        @(posedge clk);
        #1;
        // call strobe and return capture share one edge
        driveResolve(callPcC, makePc(43), brCall, 1'b1, 1'b0, ctrStrongNt, 1'b0);
        preIfPc = retPc;
        ifWr    = 1'b1;
        @(posedge clk);
        #1;
        resolveValid = 1'b0;
        ifWr         = 1'b0;
        expectLookup(retPc, 1'b1, brRetn, retCount, '0);
        resolveBranch(retPc, '0, brRetn, 1'b1, 1'b1, retCount, 1'b1);
        retCount = nextCount(1'b1, 1'b1, retCount);
    endtask

    task automatic flushAndSlot();
        logic [addrWidth-1:0] missA;
        logic [addrWidth-1:0] missB;
        missA = makePc(30);
        missB = makePc(31);
        lookup(missA);
        // a valid hit in the register so the flush has something to clear
        lookup(immPc);
        checkValue("predHit", predHit, 1'b1);
        checkValue("predValid", predValid, 1'b1);
        @(posedge clk);
        #1;
        ifFlush = 1'b1;
        @(posedge clk);
        #1;
        ifFlush = 1'b0;
        checkValue("predValid", predValid, 1'b0);
        // cleared register reads as PC zero
        expectLookup('0, 1'b0, brNone, ctrStrongNt, '0);
        lookup(callPcA);
        expectLookup(callPcA, 1'b1, brCall, ctrWeakT, callTgtA);
        checkValue("predValid", predValid, 1'b1);
        lookup(missB);
        checkValue("predValid", predValid, 1'b0);
        lookup(missA);
        checkValue("predValid", predValid, 1'b1);
    endtask

    task automatic tagAliasing();
        logic [addrWidth-1:0] aliasPc;
        // same index with the top tag bit flipped
        aliasPc = immPc ^ 32'h8000_0000;
        lookup(aliasPc);
        expectLookup(aliasPc, 1'b0, brNone, ctrStrongNt, '0);
        lookup(immPc);
        expectLookup(immPc, 1'b1, brImme, immCount, immTarget);
    endtask

    // run limit well above the length of the directed sequence
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: tests did not complete within %0d cycles", timeoutCycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        seed          = 32'h3b5a;
        reset         = 1'b1;
        preIfPc       = '0;
        ifWr          = 1'b0;
        ifFlush       = 1'b0;
        resolveValid  = 1'b0;
        resolvePc     = '0;
        resolveTarget = '0;
        resolveType   = brNone;
        resolveTaken  = 1'b0;
        resolveHit    = 1'b0;
        resolveCount  = ctrStrongNt;
        resolveRetnOk = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        coldMiss();
        counterTraining();
        callAndReturn();
        pushBypass();
        flushAndSlot();
        tagAliasing();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+tests
logic/bpuPkg.sv
logic/branchHistoryTable.sv
logic/returnAddressStack.sv
logic/predictionStage.sv
logic/branchPredictor.sv
tests/branchPredictorTb.sv
